// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
BUILD_DIR ?= build
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# status comes from the pass line in the output
run: $(SIM)
	@out="$$($(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/alu.sv
`default_nettype none

module alu
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  alu_op_t alu_op,
  input  xlen_t   operand_a,
  input  xlen_t   operand_b,
  output xlen_t   result
);

  xlen_t sum;
  xlen_t diff;

  // both paths always computed, mux picks one
  // overflow simply wraps, no flags
  assign sum  = operand_a + operand_b;
  assign diff = operand_a - operand_b;

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = sum;
      end
      alu_sub: begin
        result = diff;
      end
      alu_pass_b: begin
        // lui path
        result = operand_b;
      end
      default: begin
        // unused encoding
        result = sum;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/inst_decoder.sv
`default_nettype none

module inst_decoder
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  inst_t   inst,

  // register indices
  output reg_id_t rd,
  output reg_id_t rs1,
  output reg_id_t rs2,

  // sign-extended immediate for the current format
  output xlen_t   imm,

  // alu function and operand selects
  output alu_op_t alu_op,
  output logic    use_imm,
  output logic    use_pc,

  // jal controls
  output logic    link,
  output logic    jump,

  // system / error
  output logic    ebreak,
  output logic    illegal_inst
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  xlen_t imm_i;
  xlen_t imm_u;
  xlen_t imm_j;

  // fixed field positions
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // indices go out raw, unused ones are ignored downstream
  assign rd  = inst[11:7];
  assign rs1 = inst[19:15];
  assign rs2 = inst[24:20];

  // i-type, 12 bits sign-extended
  assign imm_i = {{52{inst[31]}}, inst[31:20]};

  // u-type, upper 20 bits, sign-extended from bit 31
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};

  // j-type, scrambled offset, bit 0 always zero
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // defaults describe a no-op that writes nothing useful
    imm          = imm_i;
    alu_op       = alu_add;
    use_imm      = 1'b0;
    use_pc       = 1'b0;
    link         = 1'b0;
    jump         = 1'b0;
    ebreak       = 1'b0;
    illegal_inst = 1'b0;

    case (opcode)
      op_imm: begin
        // only addi among the op-imm group
        use_imm = 1'b1;
        if (funct3 != funct3_add) begin
          illegal_inst = 1'b1;
        end
      end

      op_reg: begin
        // add / sub, everything else rejected
        if (funct3 != funct3_add) begin
          illegal_inst = 1'b1;
        end else if (funct7 == funct7_sub) begin
          alu_op = alu_sub;
        end else if (funct7 != funct7_base) begin
          illegal_inst = 1'b1;
        end
      end

      op_lui: begin
        imm     = imm_u;
        alu_op  = alu_pass_b;
        use_imm = 1'b1;
      end

      op_auipc: begin
        // pc + upper immediate
        imm     = imm_u;
        use_imm = 1'b1;
        use_pc  = 1'b1;
      end

      op_jal: begin
        // target computed in pc_unit, rd gets pc + 4
        imm  = imm_j;
        jump = 1'b1;
        link = 1'b1;
      end

      op_system: begin
        // exact encoding only
        if (inst == ebreak_word) begin
          ebreak = 1'b1;
        end else begin
          illegal_inst = 1'b1;
        end
      end

      default: begin
        illegal_inst = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: logic/inst_mem.sv
`default_nettype none

module inst_mem
  import rv_types_pkg::*;
(
  input  wire        clk,

  // fetch side, combinational
  input  imem_addr_t fetch_addr,
  output inst_t      inst,

  // loader side, written at the rising edge
  input  wire        load_en,
  input  imem_addr_t load_addr,
  input  inst_t      load_data
);

  // program storage
  // contents only ever come from the loader
  inst_t mem [imem_depth];

  // async read so the word is available in the same cycle as pc
  assign inst = mem[fetch_addr];

  // loader writes one word per edge
  // only used while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

endmodule

`default_nettype wire

// File: logic/pc_unit.sv
`default_nettype none

module pc_unit
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  wire   clk,
  input  wire   rst_n,

  // next-pc select
  input  wire   jump,
  input  xlen_t imm,

  // stop requests from decode
  input  wire   ebreak,
  input  wire   illegal_inst,

  output xlen_t pc,
  output logic  stopped,
  output logic  halted,
  output logic  illegal
);

  xlen_t next_pc;
  logic  advance;

  // jal target or fall-through
  assign next_pc = jump ? (pc + imm) : (pc + 64'd4);

  // either flag freezes the core
  assign stopped = halted | illegal;

  // pc stays on an ebreak / bad word so it can be inspected
  assign advance = !stopped && !ebreak && !illegal_inst;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc      <= pc_reset;
      halted  <= 1'b0;
      illegal <= 1'b0;
    end else begin
      if (advance) begin
        pc <= next_pc;
      end
      // sticky until the next reset
      if (!stopped && ebreak) begin
        halted <= 1'b1;
      end
      if (!stopped && illegal_inst) begin
        illegal <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

module reg_file
  import rv_types_pkg::*;
(
  input  wire     clk,

  // read ports, combinational
  input  reg_id_t rs1,
  input  reg_id_t rs2,
  output xlen_t   rdata_1,
  output xlen_t   rdata_2,

  // write port
  input  wire     wen,
  input  reg_id_t rd,
  input  xlen_t   wdata
);

  // x1..x31 only, x0 has no storage
  xlen_t regs [1:num_regs-1];

  // x0 always reads zero
  // a read in the write cycle sees the old value
  always_comb begin
    if (rs1 == '0) begin
      rdata_1 = '0;
    end else begin
      rdata_1 = regs[rs1];
    end
  end

  always_comb begin
    if (rs2 == '0) begin
      rdata_2 = '0;
    end else begin
      rdata_2 = regs[rs2];
    end
  end

  // writes to x0 fall on the floor
  always_ff @(posedge clk) begin
    if (wen && (rd != '0)) begin
      regs[rd] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: logic/rv_core_top.sv
`default_nettype none

module rv_core_top
  import rv_types_pkg::*;
  import rv_isa_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,

  // program loader, used while rst_n is low
  input  wire        load_en,
  input  imem_addr_t load_addr,
  input  inst_t      load_data,

  // status
  output xlen_t      pc,
  output logic       halted,
  output logic       illegal,

  // write-back trace of the current instruction
  output logic       wb_en,
  output reg_id_t    wb_rd,
  output xlen_t      wb_data
);

  inst_t      inst;
  imem_addr_t fetch_addr;

  reg_id_t rd;
  reg_id_t rs1;
  reg_id_t rs2;
  xlen_t   imm;
  alu_op_t alu_op;
  logic    use_imm;
  logic    use_pc;
  logic    link;
  logic    jump;
  logic    ebreak;
  logic    illegal_inst;

  xlen_t rdata_1;
  xlen_t rdata_2;
  xlen_t operand_a;
  xlen_t operand_b;
  xlen_t alu_result;
  logic  stopped;

  // word index from pc, byte offset dropped
  assign fetch_addr = pc[imem_addr_w+1:2];

  inst_mem u_inst_mem (
    .clk        (clk),
    .fetch_addr (fetch_addr),
    .inst       (inst),
    .load_en    (load_en),
    .load_addr  (load_addr),
    .load_data  (load_data)
  );

  inst_decoder u_inst_decoder (
    .inst         (inst),
    .rd           (rd),
    .rs1          (rs1),
    .rs2          (rs2),
    .imm          (imm),
    .alu_op       (alu_op),
    .use_imm      (use_imm),
    .use_pc       (use_pc),
    .link         (link),
    .jump         (jump),
    .ebreak       (ebreak),
    .illegal_inst (illegal_inst)
  );

  reg_file u_reg_file (
    .clk     (clk),
    .rs1     (rs1),
    .rs2     (rs2),
    .rdata_1 (rdata_1),
    .rdata_2 (rdata_2),
    .wen     (wb_en),
    .rd      (rd),
    .wdata   (wb_data)
  );

  // operand a is pc for auipc, operand b is imm for i/u forms
  assign operand_a = use_pc ? pc : rdata_1;
  assign operand_b = use_imm ? imm : rdata_2;

  alu u_alu (
    .alu_op    (alu_op),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .result    (alu_result)
  );

  pc_unit u_pc_unit (
    .clk          (clk),
    .rst_n        (rst_n),
    .jump         (jump),
    .imm          (imm),
    .ebreak       (ebreak),
    .illegal_inst (illegal_inst),
    .pc           (pc),
    .stopped      (stopped),
    .halted       (halted),
    .illegal      (illegal)
  );

  // nothing is written once frozen, nor by ebreak or a bad word
  assign wb_en = !stopped && !ebreak && !illegal_inst;
  assign wb_rd = rd;

  // jal links the return address instead of the alu result
  assign wb_data = link ? (pc + 64'd4) : alu_result;

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_reg    = 7'b0110011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 for addi / add / sub
  localparam logic [2:0] funct3_add = 3'b000;

  // funct7 selects add vs sub in the register form
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub  = 7'b0100000;

  // ebreak is matched on the whole word
  // ecall and friends share op_system and count as illegal here
  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  // first fetch address after reset
  localparam logic [63:0] pc_reset = 64'h0000_0000_8000_0000;

  // alu function select
  typedef enum logic [1:0] {
    // a + b, wrapping
    alu_add    = 2'd0,
    // a - b, wrapping
    alu_sub    = 2'd1,
    // b straight through, used by lui
    alu_pass_b = 2'd2
  } alu_op_t;

endpackage

`default_nettype wire

// File: logic/rv_types_pkg.sv
`default_nettype none

package rv_types_pkg;

  // integer register and address width
  localparam int xlen = 64;

  // fixed 32-bit encoding, no compressed forms
  localparam int ilen = 32;

  // register index width, 32 architectural registers
  localparam int reg_id_w = 5;
  localparam int num_regs = 2 ** reg_id_w;

  // instruction memory size in words
  localparam int imem_depth = 256;
  localparam int imem_addr_w = $clog2(imem_depth);

  // register values, pc and immediates
  typedef logic [xlen-1:0] xlen_t;

  // one raw instruction word
  typedef logic [ilen-1:0] inst_t;

  // rd / rs1 / rs2 index
  typedef logic [reg_id_w-1:0] reg_id_t;

  // word index into instruction memory
  // taken from pc[9:2], so fetch wraps every 1 KiB
  typedef logic [imem_addr_w-1:0] imem_addr_t;

endpackage

`default_nettype wire

// File: rv_core.f
logic/rv_types_pkg.sv
logic/rv_isa_pkg.sv
logic/inst_mem.sv
logic/inst_decoder.sv
logic/reg_file.sv
logic/alu.sv
logic/pc_unit.sv
logic/rv_core_top.sv
test/rv_core_checker.sv
test/tb_rv_core.sv

// File: test/rv_core_checker.sv
`default_nettype none

module rv_core_checker
  import rv_types_pkg::*;
(
  input wire   clk,
  input wire   rst_n,
  input xlen_t pc,
  input wire   halted,
  input wire   illegal,
  input wire   wb_en
);

  timeunit 1ns;
  timeprecision 100ps;

  // flags only clear through reset
  halted_sticky: assert property (
    @(posedge clk) $past(rst_n) && $past(halted) |-> halted
  ) else $error("halted dropped without a reset");

  illegal_sticky: assert property (
    @(posedge clk) $past(rst_n) && $past(illegal) |-> illegal
  ) else $error("illegal dropped without a reset");

  // frozen core keeps its pc
  pc_frozen: assert property (
    @(posedge clk) $past(rst_n) && $past(halted || illegal) |-> $stable(pc)
  ) else $error("pc moved while the core was stopped");

  // no write-back once stopped
  no_wb_when_stopped: assert property (
    @(posedge clk) rst_n && (halted || illegal) |-> !wb_en
  ) else $error("wb_en high while the core was stopped");

endmodule

bind rv_core_top rv_core_checker i_rv_core_checker (
  .clk     (clk),
  .rst_n   (rst_n),
  .pc      (pc),
  .halted  (halted),
  .illegal (illegal),
  .wb_en   (wb_en)
);

`default_nettype wire

// File: test/tb_rv_core.sv
`default_nettype none

module tb_rv_core
  import rv_types_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int half_period = 4;
  localparam int reset_cycles = 5;
  localparam int frozen_cycles = 10;
  localparam int random_ops = 24;

  // load + run per test, the ebreak test loads twice
  localparam int test_cycles = (9 + 8) + (34 + 33) + (6 + 5) + (6 + 5)
                             + (6 + 2 + frozen_cycles + 6 + 1) + (6 + 2 + frozen_cycles);
  localparam int watchdog_cycles = test_cycles + 200;

  // first fetch address out of reset
  localparam xlen_t reset_pc = 64'h0000_0000_8000_0000;

  // addi x0, x0, 0
  localparam inst_t nop_word = 32'h0000_0013;
  localparam inst_t brk_word = 32'h0010_0073;
  // sw x0, 0(x0), store opcode is not supported
  localparam inst_t store_word = 32'h0000_2023;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       load_en;
  imem_addr_t load_addr;
  inst_t      load_data;
  xlen_t      pc;
  logic       halted;
  logic       illegal;
  logic       wb_en;
  reg_id_t    wb_rd;
  xlen_t      wb_data;

  string test_name;
  inst_t prog[$];
  // reference state
  xlen_t model_regs[32];
  xlen_t model_pc;

  rv_core_top i_rv_core_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .halted    (halted),
    .illegal   (illegal),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data)
  );

  always #half_period clk = ~clk;

  // instruction encoders, standard rv64i layouts
  function automatic inst_t addi_word(reg_id_t rd, reg_id_t rs1, int imm);
    logic [11:0] imm12;
    imm12 = 12'(imm);
    return {imm12, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic inst_t reg_word(logic sub, reg_id_t rd, reg_id_t rs1, reg_id_t rs2);
    return {sub ? 7'b0100000 : 7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic inst_t upper_word(logic is_auipc, reg_id_t rd, logic [19:0] imm20);
    return {imm20, rd, is_auipc ? 7'b0010111 : 7'b0110111};
  endfunction

  function automatic inst_t jal_word(reg_id_t rd, int offset);
    logic [20:0] off;
    off = 21'(offset);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // signed 12-bit range, both signs
  function automatic int random_imm();
    return int'($urandom % 4096) - 2048;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_xlen(input string what, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch in %s, %s: expected %h, actual %h",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_reg_id(input string what, input reg_id_t exp, input reg_id_t act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch in %s, %s: expected x%0d, actual x%0d",
                         test_name, what, exp, act));
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      stop_run($sformatf("mismatch in %s, %s: expected %b, actual %b",
                         test_name, what, exp, act));
    end
  endtask

  // expected trace and next pc for one word at model_pc
  task automatic predict(input inst_t w, output logic en, output reg_id_t rd,
                         output xlen_t data, output xlen_t next_pc);
    xlen_t a;
    xlen_t b;
    xlen_t imm_u;
    xlen_t imm_j;
    a = model_regs[w[19:15]];
    b = model_regs[w[24:20]];
    imm_u = {{32{w[31]}}, w[31:12], 12'h000};
    imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    en = 1'b1;
    rd = w[11:7];
    next_pc = model_pc + 64'd4;
    case (w[6:0])
      7'b0010011: data = a + {{52{w[31]}}, w[31:20]};
      // bit 30 picks sub
      7'b0110011: data = w[30] ? (a - b) : (a + b);
      7'b0110111: data = imm_u;
      7'b0010111: data = model_pc + imm_u;
      7'b1101111: begin
        data = model_pc + 64'd4;
        next_pc = model_pc + imm_j;
      end
      // ebreak or a bad word, nothing written and pc holds
      default: begin
        en = 1'b0;
        data = '0;
        next_pc = model_pc;
      end
    endcase
  endtask

  task automatic start_test(input string name);
    test_name = name;
    prog.delete();
  endtask

  // reset low at least 5 cycles, longer for long programs
  task automatic load_and_reset();
    int n;
    n = (prog.size() > reset_cycles) ? prog.size() : reset_cycles;
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    for (int i = 0; i < n; i++) begin
      load_en = (i < prog.size());
      load_addr = imem_addr_t'(i);
      load_data = (i < prog.size()) ? prog[i] : nop_word;
      @(posedge clk);
      #1;
    end
    load_en = 1'b0;
    rst_n = 1'b1;
    model_pc = reset_pc;
    foreach (model_regs[r]) begin
      model_regs[r] = '0;
    end
    check_xlen("pc after reset", reset_pc, pc);
    check_bit("halted after reset", 1'b0, halted);
    check_bit("illegal after reset", 1'b0, illegal);
  endtask

  // sample mid-cycle, then step the model with the edge
  task automatic run_cycles(input int n);
    logic    exp_en;
    reg_id_t exp_rd;
    xlen_t   exp_data;
    xlen_t   exp_next;
    int      idx;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      idx = int'(model_pc[9:2]);
      if (idx >= prog.size()) begin
        stop_run($sformatf("%s: pc %h ran past the loaded program", test_name, model_pc));
      end
      predict(prog[idx], exp_en, exp_rd, exp_data, exp_next);
      check_xlen("pc", model_pc, pc);
      check_bit("halted", 1'b0, halted);
      check_bit("illegal", 1'b0, illegal);
      check_bit("wb_en", exp_en, wb_en);
      if (exp_en) begin
        check_reg_id("wb_rd", exp_rd, wb_rd);
        check_xlen("wb_data", exp_data, wb_data);
        if (exp_rd != 5'd0) begin
          model_regs[exp_rd] = exp_data;
        end
      end
      model_pc = exp_next;
      @(posedge clk);
    end
  endtask

  // core must sit still with no write-back
  task automatic expect_frozen(input logic exp_halted, input logic exp_illegal, input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      check_bit("halted while frozen", exp_halted, halted);
      check_bit("illegal while frozen", exp_illegal, illegal);
      check_bit("wb_en while frozen", 1'b0, wb_en);
      check_xlen("pc while frozen", model_pc, pc);
      @(posedge clk);
    end
  endtask

  task automatic test_nop_reset();
    start_test("nop_reset");
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    // rd x0 still shows on the trace
    prog.push_back(addi_word(5'd0, 5'd0, 123));
    // x0 as source reads zero afterwards
    prog.push_back(reg_word(1'b0, 5'd5, 5'd0, 5'd0));
    prog.push_back(addi_word(5'd6, 5'd0, -7));
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    load_and_reset();
    run_cycles(prog.size());
  endtask

  task automatic test_alu_random();
    int      kind;
    reg_id_t rd;
    reg_id_t rs1;
    reg_id_t rs2;
    start_test("alu_random");
    for (int r = 1; r < 8; r++) begin
      prog.push_back(addi_word(reg_id_t'(r), 5'd0, random_imm()));
    end
    // all ones plus one, carry out of bit 63
    prog.push_back(addi_word(5'd9, 5'd0, -1));
    prog.push_back(addi_word(5'd9, 5'd9, 1));
    for (int i = 0; i < random_ops; i++) begin
      kind = int'($urandom % 3);
      rd = reg_id_t'(1 + $urandom % 7);
      rs1 = reg_id_t'($urandom % 8);
      rs2 = reg_id_t'($urandom % 8);
      if (kind == 0) begin
        prog.push_back(addi_word(rd, rs1, random_imm()));
      end else begin
        prog.push_back(reg_word(kind == 2, rd, rs1, rs2));
      end
    end
    load_and_reset();
    run_cycles(prog.size());
  endtask

  task automatic test_upper_imm();
    start_test("upper_imm");
    prog.push_back(upper_word(1'b0, 5'd1, 20'h12345));
    // bit 31 set, sign extends
    prog.push_back(upper_word(1'b0, 5'd2, 20'hfedcb));
    prog.push_back(upper_word(1'b1, 5'd3, 20'h00001));
    // pc plus a negative upper imm wraps low
    prog.push_back(upper_word(1'b1, 5'd4, 20'h80000));
    prog.push_back(addi_word(5'd5, 5'd1, 1));
    load_and_reset();
    run_cycles(prog.size());
  endtask

  task automatic test_jal();
    start_test("jal");
    // forward to word 4
    prog.push_back(jal_word(5'd1, 16));
    // back-jump target, uses both link values
    prog.push_back(reg_word(1'b0, 5'd6, 5'd1, 5'd2));
    prog.push_back(nop_word);
    prog.push_back(nop_word);
    // backward to word 1
    prog.push_back(jal_word(5'd2, -12));
    load_and_reset();
    run_cycles(5);
  endtask

  task automatic test_ebreak();
    start_test("ebreak");
    prog.push_back(addi_word(5'd1, 5'd0, 5));
    prog.push_back(brk_word);
    prog.push_back(addi_word(5'd2, 5'd0, 7));
    load_and_reset();
    run_cycles(2);
    expect_frozen(1'b1, 1'b0, frozen_cycles);
    // reset clears halted, checked inside the load
    load_and_reset();
    run_cycles(1);
  endtask

  task automatic test_illegal();
    start_test("illegal");
    prog.push_back(addi_word(5'd3, 5'd0, 11));
    prog.push_back(store_word);
    prog.push_back(addi_word(5'd3, 5'd0, 22));
    load_and_reset();
    run_cycles(2);
    expect_frozen(1'b0, 1'b1, frozen_cycles);
  endtask

  initial begin
    rst_n = 1'b0;
    load_en = 1'b0;
    load_addr = '0;
    load_data = '0;
    void'($urandom(64387));
    test_nop_reset();
    test_alu_random();
    test_upper_imm();
    test_jal();
    test_ebreak();
    test_illegal();
    $display("Done: no errors");
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_cycles * 2 * half_period);
    stop_run($sformatf("timeout: tests still running after %0d cycles", watchdog_cycles));
  end

endmodule

`default_nettype wire
